/* source/fml_params.svh */
`ifndef FML_PARAMS_SVH
`define FML_PARAMS_SVH

// byte address width of the FML bus
`define FML_DEPTH 26

// words per burst as fixed by the protocol
`define FML_BURST 4

// word address width of the on-chip array, 256 words
`define FML_MEM_AWIDTH 8

// cycles the controller waits in front of an acknowledge
`define FML_ACK_DELAY 2

`endif

/* source/fml_pkg.sv */
package fml_pkg;

	`include "fml_params.svh"

	// index of a bus master, only 0 to 4 are used
	typedef logic [2:0] fml_master_t;

	// one burst request as a master holds it until acknowledge
	typedef struct packed {
		logic [`FML_DEPTH-1:0] adr;
		logic                  we;
		logic                  stb;
	} fml_req_t;

	// one write beat with its byte lane selects
	typedef struct packed {
		logic [7:0]  sel;
		logic [63:0] data;
	} fml_wdat_t;

endpackage

/* source/fml_arb.sv */
`timescale 1ns/1ps

`include "fml_params.svh"

module fml_arb (
	input  logic               sys_clk,
	input  logic               sys_rst,
	input  fml_pkg::fml_req_t  m_req [5],
	input  fml_pkg::fml_wdat_t m_wdat [5],
	output logic [4:0]         m_ack,
	output fml_pkg::fml_req_t  s_req,
	output fml_pkg::fml_wdat_t s_wdat,
	input  logic               s_ack
);

	import fml_pkg::*;

	localparam int BURST_BITS = $clog2(`FML_BURST);

	// the write pointer stays put for this many beats after the ack cycle
	localparam logic [BURST_BITS-1:0] WBEATS_LOAD = BURST_BITS'(`FML_BURST - 2);

	// per-owner search order, the first strobing master in the row wins
	localparam fml_master_t SEARCH [5][4] = '{
		'{3'd1, 3'd2, 3'd3, 3'd4},
		'{3'd0, 3'd3, 3'd4, 3'd2},
		'{3'd0, 3'd3, 3'd4, 3'd1},
		'{3'd0, 3'd4, 3'd1, 3'd2},
		'{3'd0, 3'd1, 3'd2, 3'd3}
	};

	fml_master_t grant;
	fml_master_t next_grant;
	fml_master_t wgrant;
	logic [BURST_BITS-1:0] wbeats;
	logic [4:0] m_stb;
	logic write_start;

	function automatic fml_master_t pick_next(
		input fml_master_t owner,
		input logic [4:0] stb
	);
		fml_master_t row;
		fml_master_t pick;
		row = (owner > 3'd4) ? 3'd4 : owner;
		pick = owner;
		// walk the row backwards so the earliest entry is the one that sticks
		for (int k = 3; k >= 0; k--) begin
			if (stb[SEARCH[row][k]])
				pick = SEARCH[row][k];
		end
		return pick;
	endfunction

	always_comb begin
		for (int i = 0; i < 5; i++) begin
			m_stb[i] = m_req[i].stb;
		end
	end

	// request steering follows the grant directly
	always_comb begin
		s_req = m_req[4];
		for (int i = 0; i < 4; i++) begin
			if (grant == fml_master_t'(i))
				s_req = m_req[i];
		end
	end

	// the owner gives up the bus once it drops its strobe or gets its ack
	always_comb begin
		next_grant = grant;
		if (!s_req.stb || s_ack)
			next_grant = pick_next(grant, m_stb);
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			grant <= 3'd0;
		else
			grant <= next_grant;
	end

	always_comb begin
		for (int i = 0; i < 5; i++) begin
			m_ack[i] = s_ack && (grant == fml_master_t'(i));
		end
	end

	assign write_start = s_req.we & s_ack;

	// write data lags the grant
	// the writer keeps the data path for its ack cycle and the three beats after it
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			wgrant <= 3'd0;
			wbeats <= '0;
		end else begin
			if (wbeats != '0)
				wbeats <= wbeats - 1'b1;
			if (write_start)
				wbeats <= WBEATS_LOAD;
			if (!write_start && wbeats == '0)
				wgrant <= next_grant;
		end
	end

	always_comb begin
		s_wdat = m_wdat[4];
		for (int i = 0; i < 4; i++) begin
			if (wgrant == fml_master_t'(i))
				s_wdat = m_wdat[i];
		end
	end

endmodule

/* source/fml_bram_ctl.sv */
`timescale 1ns/1ps

`include "fml_params.svh"

module fml_bram_ctl (
	input  logic                       sys_clk,
	input  logic                       sys_rst,
	input  fml_pkg::fml_req_t          s_req,
	input  fml_pkg::fml_wdat_t         s_wdat,
	output logic                       s_ack,
	output logic [`FML_MEM_AWIDTH-1:0] mem_addr,
	output logic                       mem_we,
	output fml_pkg::fml_wdat_t         mem_wdat
);

	localparam int BURST_BITS = $clog2(`FML_BURST);
	localparam int BASE_W = `FML_MEM_AWIDTH - BURST_BITS;
	// three bits of byte offset within a 64-bit word, then the beat index
	localparam int BASE_LSB = 3 + BURST_BITS;
	localparam int CNT_W = $clog2(`FML_ACK_DELAY + 1);
	localparam logic [BURST_BITS-1:0] LAST_BEAT = BURST_BITS'(`FML_BURST - 1);
	localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(`FML_ACK_DELAY - 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT,
		ST_ACK,
		ST_BEAT
	} state_t;

	state_t state;
	state_t state_next;
	logic [CNT_W-1:0] cnt;
	logic [BURST_BITS-1:0] beat;
	logic [BASE_W-1:0] base_q;
	logic we_q;
	logic [BASE_W-1:0] issue_base;
	logic [BURST_BITS-1:0] issue_idx;
	logic issue_we;

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (s_req.stb)
					state_next = ST_WAIT;
			end
			ST_WAIT: begin
				// a withdrawn strobe sends us back without an ack
				if (!s_req.stb)
					state_next = ST_IDLE;
				else if (cnt == '0)
					state_next = ST_ACK;
			end
			ST_ACK: begin
				state_next = ST_BEAT;
			end
			default: begin
				if (beat == LAST_BEAT)
					state_next = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= ST_IDLE;
			cnt <= '0;
			beat <= '0;
			we_q <= 1'b0;
		end else begin
			state <= state_next;
			case (state)
				ST_IDLE: cnt <= CNT_LOAD;
				ST_WAIT: cnt <= cnt - 1'b1;
				ST_ACK: begin
					beat <= '0;
					we_q <= s_req.we;
				end
				default: beat <= beat + 1'b1;
			endcase
		end
	end

	// the master may move its address after ack so the burst base is kept here
	always_ff @(posedge sys_clk) begin
		if (state == ST_ACK)
			base_q <= s_req.adr[BASE_LSB +: BASE_W];
	end

	assign s_ack = (state == ST_ACK);

	// array accesses run one cycle ahead of the beat counter
	// so that registered read data lands in the four cycles after ack
	always_comb begin
		issue_base = base_q;
		issue_idx = beat + 1'b1;
		issue_we = 1'b0;
		case (state)
			ST_ACK: begin
				issue_base = s_req.adr[BASE_LSB +: BASE_W];
				issue_idx = '0;
				issue_we = s_req.we;
			end
			ST_BEAT: begin
				issue_we = we_q && (beat != LAST_BEAT);
			end
			default: begin
				issue_we = 1'b0;
			end
		endcase
	end

	assign mem_addr = {issue_base, issue_idx};
	assign mem_we = issue_we;
	// write beats arrive on the slave bus in the same cycles they are issued
	assign mem_wdat = s_wdat;

endmodule

/* source/fml_bram_array.sv */
`timescale 1ns/1ps

`include "fml_params.svh"

module fml_bram_array (
	input  logic                       sys_clk,
	input  logic [`FML_MEM_AWIDTH-1:0] mem_addr,
	input  logic                       mem_we,
	input  fml_pkg::fml_wdat_t         mem_wdat,
	output logic [63:0]                mem_rdata
);

	localparam int DEPTH = 1 << `FML_MEM_AWIDTH;

	logic [63:0] mem [DEPTH];

	// only lanes with their select bit set are written
	always_ff @(posedge sys_clk) begin
		if (mem_we) begin
			for (int b = 0; b < 8; b++) begin
				if (mem_wdat.sel[b])
					mem[mem_addr][b*8 +: 8] <= mem_wdat.data[b*8 +: 8];
			end
		end
	end

	// read returns the word as it was before a write in the same cycle
	always_ff @(posedge sys_clk) begin
		mem_rdata <= mem[mem_addr];
	end

endmodule

/* source/fml_subsys.sv */
`timescale 1ns/1ps

`include "fml_params.svh"

module fml_subsys (
	input  logic               sys_clk,
	input  logic               sys_rst,
	input  fml_pkg::fml_req_t  m_req [5],
	input  fml_pkg::fml_wdat_t m_wdat [5],
	output logic [4:0]         m_ack,
	output logic [63:0]        rdata
);

	import fml_pkg::*;

	fml_req_t s_req;
	fml_wdat_t s_wdat;
	logic s_ack;

	logic [`FML_MEM_AWIDTH-1:0] mem_addr;
	logic mem_we;
	fml_wdat_t mem_wdat;

	fml_arb arb0 (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.m_req   (m_req),
		.m_wdat  (m_wdat),
		.m_ack   (m_ack),
		.s_req   (s_req),
		.s_wdat  (s_wdat),
		.s_ack   (s_ack)
	);

	fml_bram_ctl ctl0 (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.s_req    (s_req),
		.s_wdat   (s_wdat),
		.s_ack    (s_ack),
		.mem_addr (mem_addr),
		.mem_we   (mem_we),
		.mem_wdat (mem_wdat)
	);

	// all masters share the one read bus straight from the array
	fml_bram_array mem0 (
		.sys_clk   (sys_clk),
		.mem_addr  (mem_addr),
		.mem_we    (mem_we),
		.mem_wdat  (mem_wdat),
		.mem_rdata (rdata)
	);

endmodule

/* sim/tb_fml_subsys.sv */
`timescale 1ns/1ps

`include "fml_params.svh"

module tb_fml_subsys;

	import fml_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam int MEM_WORDS = 1 << `FML_MEM_AWIDTH;
	localparam int ACK_WAIT_MAX = 80;
	// every burst of the run with a generous cycle cost for each
	localparam int NUM_BURSTS = 22;
	localparam int BURST_CYCLES = 12;
	localparam int RUN_CYCLES = RESET_CYCLES + NUM_BURSTS * BURST_CYCLES;

	localparam logic [`FML_DEPTH-1:0] T1_ADR = 26'h0000a0;
	localparam logic [`FML_DEPTH-1:0] T3_ADR = 26'h000200;
	localparam logic [`FML_DEPTH-1:0] T4_ADR = 26'h000400;
	// far above the 2 KiB array, lands on word 0xdc below
	localparam logic [`FML_DEPTH-1:0] ALIAS_ADR = 26'h3a06e0;
	localparam logic [`FML_DEPTH-1:0] ALIAS_LOW = 26'h0006e0;

	logic sys_clk;
	logic sys_rst;
	fml_req_t m_req [5];
	fml_wdat_t m_wdat [5];
	logic [4:0] m_ack;
	logic [63:0] rdata;

	logic [63:0] ref_mem [MEM_WORDS];
	fml_wdat_t beat_tbl [5][`FML_BURST];
	integer seed;
	int err_cnt;
	int ack_err;
	int chk_cnt;
	int req_cnt [5];
	int ack_cnt [5];
	int ack_order [$];
	logic [63:0] exp_beat [`FML_BURST];
	int rd_left;
	int rd_idx;

	fml_subsys dut0 (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.m_req   (m_req),
		.m_wdat  (m_wdat),
		.m_ack   (m_ack),
		.rdata   (rdata)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
	end

	initial begin
		#(2 * RUN_CYCLES * CLK_PERIOD);
		$display("watchdog: the run did not finish within %0d cycles", 2 * RUN_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

	// word index of beat k, only the low array bits of the byte address count
	function automatic logic [`FML_MEM_AWIDTH-1:0] word_of(
		input logic [`FML_DEPTH-1:0] adr,
		input int k
	);
		logic [`FML_MEM_AWIDTH-1:0] w;
		w = adr[3 +: `FML_MEM_AWIDTH];
		w[1:0] = 2'(k);
		return w;
	endfunction

	// search lists per owner, one nibble per entry, first entry on the left
	function automatic int search_entry(input int owner, input int k);
		logic [15:0] row;
		case (owner)
			0: row = 16'h1234;
			1: row = 16'h0342;
			2: row = 16'h0341;
			3: row = 16'h0412;
			default: row = 16'h0123;
		endcase
		return int'(row[12 - 4 * k +: 4]);
	endfunction

	function automatic int next_owner(input int owner, input logic [4:0] pend);
		int pick;
		pick = -1;
		for (int k = 3; k >= 0; k--) begin
			if (pend[search_entry(owner, k)])
				pick = search_entry(owner, k);
		end
		return pick;
	endfunction

	task automatic model_write(input int m, input logic [`FML_DEPTH-1:0] adr);
		logic [`FML_MEM_AWIDTH-1:0] w;
		for (int k = 0; k < `FML_BURST; k++) begin
			w = word_of(adr, k);
			for (int b = 0; b < 8; b++) begin
				if (beat_tbl[m][k].sel[b])
					ref_mem[w][b*8 +: 8] = beat_tbl[m][k].data[b*8 +: 8];
			end
		end
	endtask

	// sels holds the byte selects of beat k in bits 8k+7..8k
	task automatic fill_beats(input int m, input logic [31:0] sels);
		for (int k = 0; k < `FML_BURST; k++) begin
			beat_tbl[m][k].sel = sels[8*k +: 8];
			beat_tbl[m][k].data = {$random(seed), $random(seed)};
		end
	endtask

	task automatic wait_for_ack(input int m, output bit seen);
		int waited;
		seen = 1'b0;
		waited = 0;
		while (!seen && waited < ACK_WAIT_MAX) begin
			@(negedge sys_clk);
			waited++;
			if (m_ack[m])
				seen = 1'b1;
		end
		if (!seen) begin
			$display("master %0d got no acknowledge within %0d cycles", m, ACK_WAIT_MAX);
			err_cnt++;
		end
	endtask

	// one burst from master m, the request is held through its ack cycle
	task automatic run_master(input int m, input logic we, input logic [`FML_DEPTH-1:0] adr);
		fml_req_t req;
		bit seen;
		req.adr = adr;
		req.we = we;
		req.stb = 1'b1;
		m_req[m] = req;
		m_wdat[m] = beat_tbl[m][0];
		req_cnt[m]++;
		wait_for_ack(m, seen);
		if (seen && we)
			model_write(m, adr);
		@(negedge sys_clk);
		m_req[m] = '0;
		if (seen && we) begin
			for (int k = 1; k < `FML_BURST; k++) begin
				m_wdat[m] = beat_tbl[m][k];
				@(negedge sys_clk);
			end
		end
	endtask

	task automatic finish_test(input int num, input string name, input int err_before);
		while (rd_left > 0)
			@(negedge sys_clk);
		for (int i = 0; i < 5; i++) begin
			chk_cnt++;
			assert (ack_cnt[i] == req_cnt[i]) else begin
				$display("Fail t=%0t ack_cnt[%0d] expected %0d got %0d",
					$time, i, req_cnt[i], ack_cnt[i]);
				err_cnt++;
				ack_err++;
			end
		end
		if (err_cnt == err_before)
			$display("test %0d %s: ok", num, name);
		else
			$display("test %0d %s: %0d errors", num, name, err_cnt - err_before);
	endtask

	// outputs are sampled on the rising edge where they have been stable all cycle
	always @(posedge sys_clk) begin
		if (!sys_rst) begin
			if (rd_left > 0) begin
				chk_cnt++;
				assert (rdata === exp_beat[rd_idx]) else begin
					$display("Fail t=%0t rdata beat %0d expected %h got %h",
						$time, rd_idx, exp_beat[rd_idx], rdata);
					err_cnt++;
				end
				rd_idx++;
				rd_left--;
			end
			chk_cnt++;
			assert ($countones(m_ack) <= 1) else begin
				$display("more than one acknowledge high at once at t=%0t", $time);
				err_cnt++;
				ack_err++;
			end
			for (int i = 0; i < 5; i++) begin
				if (m_ack[i]) begin
					ack_cnt[i]++;
					ack_order.push_back(i);
					chk_cnt++;
					assert (m_req[i].stb) else begin
						$display("master %0d acknowledged without a strobe at t=%0t", i, $time);
						err_cnt++;
						ack_err++;
					end
					if (!m_req[i].we) begin
						for (int k = 0; k < `FML_BURST; k++)
							exp_beat[k] = ref_mem[word_of(m_req[i].adr, k)];
						rd_left = `FML_BURST;
						rd_idx = 0;
					end
				end
			end
		end
	end

	initial begin
		int owner;
		int got;
		int err_before;
		logic [4:0] pend;
		bit seen_a;
		bit seen_b;
		seed = 32'h03af_4891;
		err_cnt = 0;
		ack_err = 0;
		chk_cnt = 0;
		rd_left = 0;
		rd_idx = 0;
		sys_rst = 1'b1;
		for (int i = 0; i < 5; i++) begin
			m_req[i] = '0;
			m_wdat[i] = '0;
			req_cnt[i] = 0;
			ack_cnt[i] = 0;
		end
		repeat (RESET_CYCLES) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;

		err_before = err_cnt;
		fill_beats(0, 32'hffff_ffff);
		run_master(0, 1'b1, T1_ADR);
		run_master(0, 1'b0, T1_ADR);
		finish_test(1, "write then read", err_before);

		err_before = err_cnt;
		fill_beats(0, 32'hf000_a50f);
		run_master(0, 1'b1, T1_ADR);
		run_master(0, 1'b0, T1_ADR);
		finish_test(2, "byte selects", err_before);

		// grant is still 0 since only master 0 has been on the bus
		err_before = err_cnt;
		ack_order.delete();
		for (int i = 0; i < 5; i++)
			fill_beats(i, 32'hffff_ffff);
		fork
			run_master(0, 1'b1, T3_ADR);
			run_master(1, 1'b1, T3_ADR + 26'h20);
			run_master(2, 1'b1, T3_ADR + 26'h40);
			run_master(3, 1'b1, T3_ADR + 26'h60);
			run_master(4, 1'b1, T3_ADR + 26'h80);
		join
		owner = 0;
		pend = 5'b11111;
		for (int n = 0; n < 5; n++) begin
			got = (n < ack_order.size()) ? ack_order[n] : -1;
			chk_cnt++;
			assert (got == owner) else begin
				$display("Fail t=%0t ack_order[%0d] expected %0d got %0d", $time, n, owner, got);
				err_cnt++;
			end
			pend[owner] = 1'b0;
			owner = next_owner(owner, pend);
		end
		for (int i = 0; i < 5; i++)
			run_master(0, 1'b0, T3_ADR + 26'(32 * i));
		finish_test(3, "grant order", err_before);

		// each writer starts while the previous burst is still moving its beats
		err_before = err_cnt;
		fill_beats(4, 32'hffff_ffff);
		fill_beats(1, 32'hffff_ffff);
		fill_beats(3, 32'hffff_ffff);
		fork
			run_master(4, 1'b1, T4_ADR);
			begin
				wait_for_ack(4, seen_a);
				@(negedge sys_clk);
				if (seen_a)
					run_master(1, 1'b1, T4_ADR + 26'h20);
			end
			begin
				wait_for_ack(4, seen_b);
				repeat (2) @(negedge sys_clk);
				if (seen_b)
					wait_for_ack(1, seen_b);
				@(negedge sys_clk);
				if (seen_b)
					run_master(3, 1'b1, T4_ADR + 26'h40);
			end
		join
		run_master(2, 1'b0, T4_ADR);
		run_master(2, 1'b0, T4_ADR + 26'h20);
		run_master(2, 1'b0, T4_ADR + 26'h40);
		finish_test(4, "write data ownership", err_before);

		err_before = err_cnt;
		fill_beats(3, 32'hffff_ffff);
		run_master(3, 1'b1, ALIAS_ADR);
		run_master(1, 1'b0, ALIAS_LOW);
		finish_test(6, "aliasing and read latency", err_before);

		if (ack_err == 0)
			$display("test 5 acknowledge discipline: ok");
		else
			$display("test 5 acknowledge discipline: %0d errors", ack_err);

		repeat (2) @(negedge sys_clk);
		$display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* src.f */
+incdir+source
source/fml_pkg.sv
source/fml_arb.sv
source/fml_bram_ctl.sv
source/fml_bram_array.sv
source/fml_subsys.sv
sim/tb_fml_subsys.sv
